/* hdl/fetch_pkg.sv */
// types and constants shared by the fetch front end
// fixed 4-beat INCR bursts of 64-bit beats with one burst in flight at a time
`default_nettype none

package fetch_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [63:0] beat_t;
  typedef logic [15:0] parcel_t;
  typedef logic [31:0] instr_word_t;
  typedef logic [3:0]  axi_id_t;
  typedef logic [1:0]  reg_idx_t;

  localparam int BurstBeats = 4;
  localparam int BeatBytes  = 8;
  localparam int BurstBytes = BurstBeats * BeatBytes;
  localparam int FifoDepth  = 8;
  localparam int FifoPtrW   = $clog2(FifoDepth);

  localparam logic [1:0] AxiBurstIncr = 2'b01;

  // register map with RegCount read only
  localparam reg_idx_t RegCtrl    = 2'd0;
  localparam reg_idx_t RegStartPc = 2'd1;
  localparam reg_idx_t RegCount   = 2'd2;

  // compressed instructions sit in instr[15:0] with the upper half zero
  typedef struct packed {
    addr_t       addr;
    instr_word_t instr;
    logic        compressed;
  } fetch_out_t;

  typedef struct packed {
    logic        write;
    reg_idx_t    idx;
    logic [31:0] wdata;
  } reg_req_t;

  typedef enum logic [1:0] {
    IDLE,
    ADDR,
    DATA,
    DRAIN
  } ar_state_t;

  typedef enum logic {
    SKIP,
    RUN
  } align_state_t;

endpackage

`default_nettype wire

/* hdl/fetch_fifo.sv */
// first-word fall-through beat buffer
// flush wins over a push or pop in the same cycle
`default_nettype none

module fetch_fifo (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             flush,
  input  logic             push,
  input  logic             pop,
  input  fetch_pkg::beat_t push_beat,
  output fetch_pkg::beat_t head,
  output logic             empty,
  output logic [3:0]       free
);
  import fetch_pkg::*;

  beat_t               mem [FifoDepth];
  logic [FifoPtrW-1:0] wr_ptr;
  logic [FifoPtrW-1:0] rd_ptr;
  logic [3:0]          count;
  logic                do_push;
  logic                do_pop;

  assign empty = (count == 4'd0);
  assign free  = 4'(FifoDepth) - count;
  assign head  = mem[rd_ptr];

  assign do_push = push && (free != 4'd0) && !flush;
  assign do_pop  = pop && !empty && !flush;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= 4'd0;
    end else if (flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= 4'd0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + 4'(do_push) - 4'(do_pop);
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_beat;
    end
  end

endmodule

`default_nettype wire

/* hdl/axi_fetch_ctrl.sv */
// AXI4 read master for instruction fetch with one burst outstanding
// a burst is only issued with room for all its beats, so rready stays high
// rresp is not checked
`default_nettype none

module axi_fetch_ctrl (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               enable,
  input  logic               redirect,
  input  fetch_pkg::addr_t   start_pc,
  output fetch_pkg::axi_id_t arid,
  output fetch_pkg::addr_t   araddr,
  output logic [7:0]         arlen,
  output logic [2:0]         arsize,
  output logic [1:0]         arburst,
  output logic               arvalid,
  input  logic               arready,
  input  fetch_pkg::beat_t   rdata,
  input  logic [1:0]         rresp,
  input  logic               rlast,
  input  logic               rvalid,
  output logic               rready,
  input  logic [3:0]         fifo_free,
  output logic               push,
  output fetch_pkg::beat_t   push_beat
);
  import fetch_pkg::*;

  ar_state_t state;
  ar_state_t state_d;
  addr_t     fetch_addr;
  addr_t     ar_addr;
  logic      stale;
  logic      launch;
  logic      ar_fire;
  logic      r_fire;

  assign arid    = '0;
  assign arlen   = 8'(BurstBeats - 1);
  assign arsize  = 3'($clog2(BeatBytes));
  assign arburst = AxiBurstIncr;
  assign araddr  = ar_addr;
  assign arvalid = (state == ADDR);
  assign rready  = 1'b1;

  assign ar_fire = arvalid && arready;
  assign r_fire  = rvalid && rready;
  // hold off for a cycle on redirect so the new address is used
  assign launch  = enable && !redirect && (fifo_free >= 4'(BurstBeats));

  assign push      = r_fire && (state == DATA);
  assign push_beat = rdata;

  always_comb begin
    state_d = state;
    unique case (state)
      IDLE:    if (launch) state_d = ADDR;
      // an address already presented cannot change so its data is dropped
      ADDR:    if (ar_fire) state_d = (stale || redirect) ? DRAIN : DATA;
      DATA: begin
        if (r_fire && rlast) state_d = IDLE;
        else if (redirect) state_d = DRAIN;
      end
      DRAIN:   if (r_fire && rlast) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= IDLE;
      stale      <= 1'b0;
      fetch_addr <= '0;
    end else begin
      state <= state_d;
      stale <= (state == ADDR) && !ar_fire && (stale || redirect);
      if (redirect) begin
        fetch_addr <= start_pc & ~addr_t'(BeatBytes - 1);
      end else if (state == IDLE && launch) begin
        fetch_addr <= fetch_addr + addr_t'(BurstBytes);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == IDLE && launch) begin
      ar_addr <= fetch_addr;
    end
  end

endmodule

`default_nettype wire

/* hdl/instr_aligner.sv */
// cuts FIFO beats into parcels and emits one instruction per transfer
// only the low two bits of a parcel are decoded
`default_nettype none

module instr_aligner (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  redirect,
  input  fetch_pkg::addr_t      start_pc,
  input  fetch_pkg::beat_t      head,
  input  logic                  empty,
  output logic                  pop,
  output logic                  out_valid,
  input  logic                  out_ready,
  output fetch_pkg::fetch_out_t out_data
);
  import fetch_pkg::*;

  align_state_t state;
  logic [1:0]   idx;
  logic [1:0]   skip_to;
  addr_t        pc;
  parcel_t      carry;
  logic         carry_valid;

  parcel_t      cur;
  parcel_t      nxt;
  logic         slot_free;
  logic         emit;
  logic         load_carry;
  logic [1:0]   consume;
  logic [2:0]   pos;
  instr_word_t  instr;
  logic         compressed;

  assign cur       = head[{idx, 4'b0000} +: 16];
  assign nxt       = head[{idx + 2'd1, 4'b0000} +: 16];
  assign slot_free = !out_valid || out_ready;

  always_comb begin
    emit       = 1'b0;
    load_carry = 1'b0;
    consume    = 2'd0;
    instr      = '0;
    compressed = 1'b0;
    if (state == RUN && slot_free && !empty) begin
      if (carry_valid) begin
        // upper half of an instruction that crossed the beat boundary
        emit    = 1'b1;
        instr   = {cur, carry};
        consume = 2'd1;
      end else if (cur[1:0] != 2'b11) begin
        emit       = 1'b1;
        instr      = {16'h0000, cur};
        compressed = 1'b1;
        consume    = 2'd1;
      end else if (idx != 2'd3) begin
        emit    = 1'b1;
        instr   = {nxt, cur};
        consume = 2'd2;
      end else begin
        load_carry = 1'b1;
        consume    = 2'd1;
      end
    end
  end

  // pop once the parcel pointer runs past the last parcel of the beat
  assign pos = {1'b0, idx} + {1'b0, consume};
  assign pop = pos[2];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= SKIP;
      idx         <= 2'd0;
      skip_to     <= 2'd0;
      pc          <= '0;
      carry_valid <= 1'b0;
      out_valid   <= 1'b0;
    end else if (redirect) begin
      state       <= SKIP;
      idx         <= 2'd0;
      skip_to     <= start_pc[2:1];
      pc          <= start_pc;
      carry_valid <= 1'b0;
      out_valid   <= 1'b0;
    end else begin
      if (state == SKIP) begin
        if (idx == skip_to) state <= RUN;
        else idx <= idx + 2'd1;
      end else begin
        idx <= pos[1:0];
      end
      if (emit) pc <= pc + (compressed ? addr_t'(2) : addr_t'(4));
      if (consume != 2'd0) carry_valid <= load_carry;
      if (slot_free) out_valid <= emit;
    end
  end

  always_ff @(posedge clk) begin
    if (load_carry) carry <= cur;
    if (emit) out_data <= '{addr: pc, instr: instr, compressed: compressed};
  end

endmodule

`default_nettype wire

/* hdl/fetch_csr.sv */
// control registers where every access completes in the cycle it is presented
// writing the start address redirects the fetch on the next edge
`default_nettype none

module fetch_csr (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                reg_valid,
  output logic                reg_ready,
  input  fetch_pkg::reg_req_t reg_req,
  output logic [31:0]         reg_rdata,
  input  logic                delivered,
  output logic                enable,
  output fetch_pkg::addr_t    start_pc,
  output logic                redirect
);
  import fetch_pkg::*;

  logic [31:0] count;
  logic        wr_en;

  assign reg_ready = 1'b1;
  assign wr_en     = reg_valid && reg_req.write;

  always_comb begin
    unique case (reg_req.idx)
      RegCtrl:    reg_rdata = {31'd0, enable};
      RegStartPc: reg_rdata = start_pc;
      RegCount:   reg_rdata = count;
      default:    reg_rdata = 32'd0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      enable   <= 1'b0;
      start_pc <= '0;
      redirect <= 1'b0;
      count    <= 32'd0;
    end else begin
      redirect <= wr_en && (reg_req.idx == RegStartPc);
      if (wr_en && reg_req.idx == RegCtrl) enable <= reg_req.wdata[0];
      // instructions are halfword aligned
      if (wr_en && reg_req.idx == RegStartPc) start_pc <= {reg_req.wdata[31:1], 1'b0};
      if (redirect) count <= 32'd0;
      else if (delivered) count <= count + 32'd1;
    end
  end

endmodule

`default_nettype wire

/* hdl/ifu_top.sv */
// instruction fetch front end that turns AXI4 read bursts into an instruction stream
`default_nettype none

module ifu_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  reg_valid,
  output logic                  reg_ready,
  input  fetch_pkg::reg_req_t   reg_req,
  output logic [31:0]           reg_rdata,
  output fetch_pkg::axi_id_t    arid,
  output fetch_pkg::addr_t      araddr,
  output logic [7:0]            arlen,
  output logic [2:0]            arsize,
  output logic [1:0]            arburst,
  output logic                  arvalid,
  input  logic                  arready,
  input  fetch_pkg::beat_t      rdata,
  input  logic [1:0]            rresp,
  input  logic                  rlast,
  input  logic                  rvalid,
  output logic                  rready,
  output logic                  out_valid,
  input  logic                  out_ready,
  output fetch_pkg::fetch_out_t out_data
);
  import fetch_pkg::*;

  logic       enable;
  logic       redirect;
  addr_t      start_pc;
  logic [3:0] fifo_free;
  logic       push;
  beat_t      push_beat;
  beat_t      head;
  logic       empty;
  logic       pop;
  logic       delivered;

  assign delivered = out_valid && out_ready;

  fetch_csr csr_i (
    .clk, .rst_n, .reg_valid, .reg_ready, .reg_req, .reg_rdata,
    .delivered, .enable, .start_pc, .redirect
  );

  axi_fetch_ctrl ctrl_i (
    .clk, .rst_n, .enable, .redirect, .start_pc,
    .arid, .araddr, .arlen, .arsize, .arburst, .arvalid, .arready,
    .rdata, .rresp, .rlast, .rvalid, .rready,
    .fifo_free, .push, .push_beat
  );

  // redirect empties the buffer on the same edge the aligner restarts
  fetch_fifo fifo_i (
    .clk, .rst_n, .flush(redirect), .push, .pop, .push_beat,
    .head, .empty, .free(fifo_free)
  );

  instr_aligner align_i (
    .clk, .rst_n, .redirect, .start_pc, .head, .empty, .pop,
    .out_valid, .out_ready, .out_data
  );

endmodule

`default_nettype wire

/* sim/axi_rom_model.sv */
// AXI4 read slave for the testbench serving 4-beat INCR bursts of 64-bit words
// words come from the testbench memory through word_idx and wrap at 4 KB
`default_nettype none

module axi_rom_model (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             stall,
  input  fetch_pkg::addr_t araddr,
  input  logic             arvalid,
  output logic             arready,
  output fetch_pkg::beat_t rdata,
  output logic             rlast,
  output logic             rvalid,
  input  logic             rready,
  output logic [8:0]       word_idx,
  input  fetch_pkg::beat_t word
);
  timeunit 1ns;
  timeprecision 1ps;
  import fetch_pkg::*;

  addr_t      burst_addr;
  logic       ar_hs;
  logic       r_hs;
  logic       busy;
  logic [1:0] beat_cnt;

  assign word_idx = burst_addr[11:3] + 9'(beat_cnt);
  assign rdata    = word;

  initial begin
    arready    = 1'b0;
    rvalid     = 1'b0;
    rlast      = 1'b0;
    busy       = 1'b0;
    beat_cnt   = 2'd0;
    burst_addr = '0;
  end

  // handshakes are taken on the rising edge and outputs move on the falling one
  always @(posedge clk) begin
    ar_hs <= rst_n && arvalid && arready;
    r_hs  <= rst_n && rvalid && rready;
    if (arvalid && arready) burst_addr <= araddr;
  end

  always @(negedge clk) begin
    if (!rst_n) begin
      busy     = 1'b0;
      beat_cnt = 2'd0;
      arready  = 1'b0;
      rvalid   = 1'b0;
      rlast    = 1'b0;
    end else begin
      if (ar_hs) begin
        busy     = 1'b1;
        beat_cnt = 2'd0;
      end else if (r_hs) begin
        if (rlast) busy = 1'b0;
        else beat_cnt = beat_cnt + 2'd1;
      end
      arready = !busy && (!stall || $urandom_range(0, 3) != 0);
      rvalid  = busy && (!stall || $urandom_range(0, 2) != 0);
      rlast   = busy && (beat_cnt == 2'(BurstBeats - 1));
    end
  end

endmodule

`default_nettype wire

/* sim/ifu_tb.sv */
// directed tests for the fetch front end against a parcel-walking reference
// memory is 512 words and the ROM wraps addresses above 4 KB
`default_nettype none

module ifu_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import fetch_pkg::*;

  localparam int TotalInstr    = 3 * 64 + 12 + 24 + 16 + 40;
  localparam int TimeoutCycles = TotalInstr * 40 + 2000;

  logic        clk;
  logic        rst_n;
  logic        reg_valid;
  logic        reg_ready;
  reg_req_t    reg_req;
  logic [31:0] reg_rdata;
  axi_id_t     arid;
  addr_t       araddr;
  logic [7:0]  arlen;
  logic [2:0]  arsize;
  logic [1:0]  arburst;
  logic        arvalid;
  logic        arready;
  beat_t       rdata;
  logic [1:0]  rresp;
  logic        rlast;
  logic        rvalid;
  logic        rready;
  logic        out_valid;
  logic        out_ready;
  fetch_out_t  out_data;
  logic        stall;
  logic [8:0]  word_idx;

  beat_t mem [512];
  addr_t exp_pc;
  int    errors = 0;
  int    checks = 0;
  int    cycles = 0;

  ifu_top dut_i (
    .clk, .rst_n, .reg_valid, .reg_ready, .reg_req, .reg_rdata,
    .arid, .araddr, .arlen, .arsize, .arburst, .arvalid, .arready,
    .rdata, .rresp, .rlast, .rvalid, .rready,
    .out_valid, .out_ready, .out_data
  );

  axi_rom_model rom_i (
    .clk, .rst_n, .stall, .araddr, .arvalid, .arready,
    .rdata, .rlast, .rvalid, .rready, .word_idx, .word(mem[word_idx])
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TimeoutCycles) begin
      $display("timeout: the run did not finish within %0d cycles", cycles);
      $display("** FAIL **");
      $finish;
    end
  end

  function automatic parcel_t parcel_at(addr_t a);
    beat_t w;
    w = mem[a[11:3]];
    return w[16 * a[2:1] +: 16];
  endfunction

  // a parcel ending in 11 starts a 32-bit instruction
  function automatic fetch_out_t expect_at(addr_t a);
    parcel_t    lo;
    fetch_out_t e;
    lo = parcel_at(a);
    e.addr = a;
    if (lo[1:0] == 2'b11) begin
      e.instr      = {parcel_at(a + 32'd2), lo};
      e.compressed = 1'b0;
    end else begin
      e.instr      = {16'h0000, lo};
      e.compressed = 1'b1;
    end
    return e;
  endfunction

  task automatic check_out(fetch_out_t exp, fetch_out_t got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR out_data: expected addr %h instr %h c %h, got addr %h instr %h c %h",
               exp.addr, exp.instr, exp.compressed, got.addr, got.instr, got.compressed);
    end
  endtask

  task automatic check_reg(string name, logic [31:0] exp, logic [31:0] got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %s: expected %h, got %h", name, exp, got);
    end
  endtask

  task automatic compare_bit(string name, logic exp, logic got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %s: expected %h, got %h", name, exp, got);
    end
  endtask

  // AR fields are fixed for 4-beat INCR bursts of 8-byte beats
  task automatic inspect_ar();
    check_reg("arid", 32'd0, 32'(arid));
    check_reg("arlen", 32'd3, 32'(arlen));
    check_reg("arsize", 32'd3, 32'(arsize));
    check_reg("arburst", 32'd1, 32'(arburst));
  endtask

  task automatic write_reg(reg_idx_t idx, logic [31:0] data);
    @(negedge clk);
    reg_valid = 1'b1;
    reg_req   = '{write: 1'b1, idx: idx, wdata: data};
    @(negedge clk);
    reg_valid     = 1'b0;
    reg_req.write = 1'b0;
  endtask

  task automatic read_reg(reg_idx_t idx, output logic [31:0] data);
    @(negedge clk);
    reg_valid = 1'b1;
    reg_req   = '{write: 1'b0, idx: idx, wdata: 32'd0};
    #1;
    data = reg_rdata;
    compare_bit("reg_ready", 1'b1, reg_ready);
    @(negedge clk);
    reg_valid = 1'b0;
  endtask

  // waits out the redirect cycle so the old stream cannot transfer
  task automatic set_pc(addr_t pc);
    out_ready = 1'b0;
    write_reg(RegStartPc, pc);
    @(negedge clk);
    exp_pc = pc;
  endtask

  task automatic take_output();
    fetch_out_t e;
    e = expect_at(exp_pc);
    check_out(e, out_data);
    exp_pc = exp_pc + (e.compressed ? 32'd2 : 32'd4);
  endtask

  task automatic collect(int n, bit rand_ready, bit until_ar);
    int got;
    got = 0;
    forever begin
      @(negedge clk);
      if (got >= n && (!until_ar || arvalid)) break;
      if (arvalid) inspect_ar();
      out_ready = rand_ready ? ($urandom_range(0, 3) != 0) : 1'b1;
      if (out_valid && out_ready) begin
        take_output();
        got++;
      end
    end
    out_ready = 1'b0;
  endtask

  // runs until the stream has been quiet for 40 cycles
  task automatic drain_stream(output int got);
    int   idle;
    logic prev_ar;
    got     = 0;
    idle    = 0;
    prev_ar = arvalid;
    while (idle < 40) begin
      @(negedge clk);
      out_ready = 1'b1;
      if (arvalid && !prev_ar) begin
        errors++;
        $display("a new burst was requested after fetch was disabled");
      end
      prev_ar = arvalid;
      if (out_valid) begin
        take_output();
        got++;
        idle = 0;
      end else begin
        idle++;
      end
    end
    out_ready = 1'b0;
  endtask

  // every parcel pair is a 32-bit instruction carrying its own address
  task automatic fill_linear();
    addr_t a;
    for (int i = 0; i < 512; i++) begin
      for (int j = 0; j < 4; j++) begin
        a = 32'(i * 8 + j * 2);
        mem[i][16 * j +: 16] = (j % 2 == 0) ? {a[13:0], 2'b11} : ~a[15:0];
      end
    end
  endtask

  task automatic fill_random();
    for (int i = 0; i < 512; i++) mem[i] = {$urandom, $urandom};
  endtask

  task automatic report(string name, int err_start);
    if (errors == err_start) $display("%s: ok", name);
    else $display("%s: failed with %0d errors", name, errors - err_start);
  endtask

  task automatic reset_state();
    int          e0;
    logic [31:0] val;
    e0 = errors;
    compare_bit("out_valid", 1'b0, out_valid);
    compare_bit("arvalid", 1'b0, arvalid);
    compare_bit("rready", 1'b1, rready);
    read_reg(RegCount, val);
    check_reg("reg_count", 32'd0, val);
    report("reset state", e0);
  endtask

  task automatic linear_fetch();
    int e0;
    e0 = errors;
    fill_linear();
    set_pc(32'h100);
    write_reg(RegCtrl, 32'd1);
    collect(64, 1'b0, 1'b0);
    report("linear fetch", e0);
  endtask

  task automatic unaligned_fetch();
    int e0;
    e0 = errors;
    fill_random();
    set_pc(32'h206);
    collect(64, 1'b0, 1'b0);
    report("unaligned mixed fetch", e0);
  endtask

  task automatic stalled_fetch();
    int e0;
    e0 = errors;
    stall = 1'b1;
    set_pc(32'h402);
    collect(64, 1'b1, 1'b0);
    report("back-pressure", e0);
  endtask

  task automatic redirect_in_flight();
    int e0;
    e0 = errors;
    set_pc(32'h600);
    collect(12, 1'b1, 1'b1);
    set_pc(32'h80a);
    collect(24, 1'b1, 1'b0);
    report("redirect in flight", e0);
  endtask

  task automatic disabled_fetch();
    int          e0;
    int          drained;
    logic [31:0] val;
    e0 = errors;
    set_pc(32'ha00);
    collect(16, 1'b0, 1'b0);
    write_reg(RegCtrl, 32'd0);
    drain_stream(drained);
    read_reg(RegCount, val);
    check_reg("reg_count", 32'(16 + drained), val);
    report("enable cleared", e0);
  endtask

  initial begin
    void'($urandom(32'h3f6c));
    rst_n     = 1'b0;
    reg_valid = 1'b0;
    reg_req   = '0;
    rresp     = 2'b00;
    out_ready = 1'b0;
    stall     = 1'b0;
    exp_pc    = '0;
    for (int i = 0; i < 512; i++) mem[i] = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    reset_state();
    linear_fetch();
    unaligned_fetch();
    stalled_fetch();
    redirect_in_flight();
    disabled_fetch();

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
hdl/fetch_pkg.sv
hdl/fetch_fifo.sv
hdl/axi_fetch_ctrl.sv
hdl/instr_aligner.sv
hdl/fetch_csr.sv
hdl/ifu_top.sv
sim/axi_rom_model.sv
sim/ifu_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --top-module ifu_tb -f filelist.f -o ifu_sim
out=$(./obj_dir/ifu_sim)
echo "$out"

if echo "$out" | grep -qxF '** PASS **'; then
  exit 0
fi
exit 1
